//--- verilog/lce_pkg.sv
// LCE command handler definitions
package lce_pkg;

  // cache and system geometry
  localparam int paddr_width  = 32;
  localparam int sets         = 64;
  localparam int assoc        = 8;
  localparam int block_width  = 128;
  localparam int lce_id_width = 4;
  localparam int num_cce      = 2;

  // address split and counter width
  localparam int offset_width = $clog2(block_width / 8);
  localparam int index_width  = $clog2(sets);
  localparam int way_width    = $clog2(assoc);
  localparam int tag_width    = paddr_width - index_width - offset_width;
  localparam int cnt_width    = index_width + 1;

  typedef enum logic [2:0] {
    e_coh_i, e_coh_s, e_coh_e, e_coh_m, e_coh_o, e_coh_f
  } coh_state_e;

  // commands from the directory
  typedef enum logic [3:0] {
    e_cmd_sync, e_cmd_inv, e_cmd_st, e_cmd_data, e_cmd_wb, e_cmd_uc_st_done
  } cmd_type_e;

  // responses back to the directory
  typedef enum logic [3:0] {
    e_resp_sync_ack, e_resp_inv_ack, e_resp_coh_ack, e_resp_null_wb, e_resp_wb
  } resp_type_e;

  typedef enum logic [1:0] {
    e_tag_set_clear, e_tag_set_state, e_tag_set_tag
  } tag_op_e;

  typedef enum logic [1:0] {
    e_stat_set_clear, e_stat_read, e_stat_clear_dirty
  } stat_op_e;

  typedef enum logic {
    e_data_write, e_data_read
  } data_op_e;

  // one message-type field, seen as a command or as a response
  typedef union packed {
    cmd_type_e  cmd;
    resp_type_e resp;
  } msg_type_u;

  typedef struct packed {
    msg_type_u                msg_type;
    logic [paddr_width-1:0]   addr;
    logic [lce_id_width-1:0]  src_id;
    logic [way_width-1:0]     way_id;
    coh_state_e               state;
    logic [block_width-1:0]   data;
  } lce_cmd_msg_s;

  typedef struct packed {
    msg_type_u                msg_type;
    logic [paddr_width-1:0]   addr;
    logic [lce_id_width-1:0]  src_id;
    logic [lce_id_width-1:0]  dst_id;
    logic [block_width-1:0]   data;
  } lce_resp_msg_s;

  // cache memory packets
  typedef struct packed {
    tag_op_e                  opcode;
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way_id;
    coh_state_e               state;
    logic [tag_width-1:0]     tag;
  } tag_mem_pkt_s;

  typedef struct packed {
    stat_op_e                 opcode;
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way_id;
  } stat_mem_pkt_s;

  typedef struct packed {
    data_op_e                 opcode;
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way_id;
    logic [block_width-1:0]   data;
  } data_mem_pkt_s;

  // dirty bit per way of the set that was read
  typedef struct packed {
    logic [assoc-1:0] dirty;
  } stat_info_s;

endpackage

//--- verilog/lce_read_buffer.sv
// Memory read return buffer
module lce_read_buffer #(
  parameter int width = 8
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             read_i,
  input  logic [width-1:0] mem_i,
  output logic [width-1:0] buf_o,
  output logic             buf_v_o
);

  logic read_r;

  // read data shows up one cycle after the read is accepted
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      read_r  <= 1'b0;
      buf_v_o <= 1'b0;
    end else begin
      read_r <= read_i;
      // a newer read wins over the capture of an older one
      if (read_i) begin
        buf_v_o <= 1'b0;
      end else if (read_r) begin
        buf_v_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_r) begin
      buf_o <= mem_i;
    end
  end

endmodule

//--- verilog/lce_init_sync.sv
// Clear walk and sync counter
module lce_init_sync (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         clear_step_i,
  input  logic                         sync_step_i,
  output logic [lce_pkg::cnt_width-1:0] count_o,
  output logic                         clear_last_o,
  output logic                         sync_last_o,
  output logic                         ready_o,
  output logic                         sync_done_o
);

  import lce_pkg::*;

  logic walk_done;
  logic sync_end;

  assign clear_last_o = (count_o == cnt_width'(sets - 1));
  assign sync_last_o  = (count_o == cnt_width'(num_cce - 1));

  assign walk_done = clear_step_i & clear_last_o;
  assign sync_end  = sync_step_i & sync_last_o;

  // one counter holds the set index of the walk and then the sync count
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_o <= '0;
    end else if (walk_done || sync_end) begin
      count_o <= '0;
    end else if (clear_step_i || sync_step_i) begin
      count_o <= count_o + 1'b1;
    end
  end

  // both flags stay set until the next reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_o     <= 1'b0;
      sync_done_o <= 1'b0;
    end else begin
      if (walk_done) begin
        ready_o <= 1'b1;
      end
      if (sync_end) begin
        sync_done_o <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/lce_cmd_fsm.sv
// LCE command sequencer
module lce_cmd_fsm (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [lce_pkg::lce_id_width-1:0] lce_id_i,

  output lce_pkg::tag_mem_pkt_s          tag_mem_pkt_o,
  output logic                           tag_mem_pkt_v_o,
  input  logic                           tag_mem_pkt_yumi_i,
  output lce_pkg::stat_mem_pkt_s         stat_mem_pkt_o,
  output logic                           stat_mem_pkt_v_o,
  input  logic                           stat_mem_pkt_yumi_i,
  output lce_pkg::data_mem_pkt_s         data_mem_pkt_o,
  output logic                           data_mem_pkt_v_o,
  input  logic                           data_mem_pkt_yumi_i,

  input  lce_pkg::lce_cmd_msg_s          lce_cmd_i,
  input  logic                           lce_cmd_v_i,
  output logic                           lce_cmd_yumi_o,
  output lce_pkg::lce_resp_msg_s         lce_resp_o,
  output logic                           lce_resp_v_o,
  input  logic                           lce_resp_ready_i,

  output logic                           cache_req_complete_o,
  output logic                           uc_store_req_complete_o,

  output logic                           clear_step_o,
  output logic                           sync_step_o,
  input  logic [lce_pkg::cnt_width-1:0]  count_i,
  input  logic                           clear_last_i,
  input  logic                           sync_last_i,
  input  logic                           ready_i,

  output logic                           stat_read_o,
  output logic                           data_read_o,
  input  lce_pkg::stat_info_s            stat_buf_i,
  input  logic                           stat_buf_v_i,
  input  logic [lce_pkg::block_width-1:0] data_buf_i,
  input  logic                           data_buf_v_i
);

  import lce_pkg::*;

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_coh_ack, e_wb, e_wb_dirty_rd, e_wb_dirty_send
  } state_e;

  state_e state_r, state_n;

  logic [index_width-1:0] cmd_index;
  logic [tag_width-1:0]   cmd_tag;
  logic [way_width-1:0]   cmd_way;
  logic                   resp_send;
  logic                   line_dirty;

  assign cmd_index  = lce_cmd_i.addr[offset_width +: index_width];
  assign cmd_tag    = lce_cmd_i.addr[paddr_width-1 -: tag_width];
  assign cmd_way    = lce_cmd_i.way_id;
  assign line_dirty = stat_buf_i.dirty[cmd_way];

  // the response only goes out while the directory side is ready
  assign lce_resp_v_o = resp_send & lce_resp_ready_i;

  always_comb begin
    state_n = state_r;
    tag_mem_pkt_o = '0;
    tag_mem_pkt_v_o = 1'b0;
    stat_mem_pkt_o = '0;
    stat_mem_pkt_v_o = 1'b0;
    data_mem_pkt_o = '0;
    data_mem_pkt_v_o = 1'b0;
    lce_cmd_yumi_o = 1'b0;
    resp_send = 1'b0;
    cache_req_complete_o = 1'b0;
    uc_store_req_complete_o = 1'b0;
    clear_step_o = 1'b0;
    sync_step_o = 1'b0;
    stat_read_o = 1'b0;
    data_read_o = 1'b0;

    // every response answers the command at the head of the queue
    lce_resp_o = '0;
    lce_resp_o.addr = lce_cmd_i.addr;
    lce_resp_o.src_id = lce_id_i;
    lce_resp_o.dst_id = lce_cmd_i.src_id;

    tag_mem_pkt_o.index = cmd_index;
    tag_mem_pkt_o.way_id = cmd_way;
    stat_mem_pkt_o.index = cmd_index;
    stat_mem_pkt_o.way_id = cmd_way;
    data_mem_pkt_o.index = cmd_index;
    data_mem_pkt_o.way_id = cmd_way;

    unique case (state_r)
      e_reset: begin
        // leave reset with the shared counter at rest
        if (!clear_last_i && !sync_last_i) begin
          state_n = e_clear;
        end
      end

      // invalidate every set before taking commands
      e_clear: begin
        tag_mem_pkt_o = '0;
        tag_mem_pkt_o.opcode = e_tag_set_clear;
        tag_mem_pkt_o.index = count_i[index_width-1:0];
        tag_mem_pkt_o.state = e_coh_i;
        tag_mem_pkt_v_o = 1'b1;
        stat_mem_pkt_o = '0;
        stat_mem_pkt_o.opcode = e_stat_set_clear;
        stat_mem_pkt_o.index = count_i[index_width-1:0];
        stat_mem_pkt_v_o = 1'b1;
        clear_step_o = tag_mem_pkt_yumi_i & stat_mem_pkt_yumi_i;
        if (clear_step_o && clear_last_i) begin
          state_n = e_ready;
        end
      end

      e_ready: begin
        if (lce_cmd_v_i && ready_i) begin
          unique case (lce_cmd_i.msg_type.cmd)
            e_cmd_sync: begin
              lce_resp_o.msg_type.resp = e_resp_sync_ack;
              resp_send = 1'b1;
              lce_cmd_yumi_o = lce_resp_v_o;
              sync_step_o = lce_resp_v_o;
            end
            e_cmd_inv: begin
              tag_mem_pkt_o.opcode = e_tag_set_state;
              tag_mem_pkt_o.state = e_coh_i;
              tag_mem_pkt_v_o = 1'b1;
              lce_resp_o.msg_type.resp = e_resp_inv_ack;
              resp_send = tag_mem_pkt_yumi_i;
              lce_cmd_yumi_o = lce_resp_v_o;
            end
            e_cmd_st: begin
              tag_mem_pkt_o.opcode = e_tag_set_state;
              tag_mem_pkt_o.state = lce_cmd_i.state;
              tag_mem_pkt_v_o = 1'b1;
              lce_cmd_yumi_o = tag_mem_pkt_yumi_i;
            end
            e_cmd_data: begin
              tag_mem_pkt_o.opcode = e_tag_set_tag;
              tag_mem_pkt_o.state = lce_cmd_i.state;
              tag_mem_pkt_o.tag = cmd_tag;
              tag_mem_pkt_v_o = 1'b1;
              data_mem_pkt_o.opcode = e_data_write;
              data_mem_pkt_o.data = lce_cmd_i.data;
              data_mem_pkt_v_o = 1'b1;
              // rewriting the same tag and block is harmless, so retry until both land
              if (tag_mem_pkt_yumi_i && data_mem_pkt_yumi_i) begin
                state_n = e_coh_ack;
              end
            end
            e_cmd_wb: begin
              stat_mem_pkt_o.opcode = e_stat_read;
              stat_mem_pkt_v_o = 1'b1;
              stat_read_o = stat_mem_pkt_yumi_i;
              if (stat_mem_pkt_yumi_i) begin
                state_n = e_wb;
              end
            end
            e_cmd_uc_st_done: begin
              lce_cmd_yumi_o = 1'b1;
              uc_store_req_complete_o = 1'b1;
            end
            // drop an unknown opcode so the queue keeps moving
            default: begin
              lce_cmd_yumi_o = 1'b1;
            end
          endcase
        end
      end

      e_coh_ack: begin
        lce_resp_o.msg_type.resp = e_resp_coh_ack;
        resp_send = 1'b1;
        lce_cmd_yumi_o = lce_resp_v_o;
        cache_req_complete_o = lce_resp_v_o;
        if (lce_resp_v_o) begin
          state_n = e_ready;
        end
      end

      // wait for the dirty bit, then answer or go fetch the block
      e_wb: begin
        lce_resp_o.msg_type.resp = e_resp_null_wb;
        resp_send = stat_buf_v_i & ~line_dirty;
        lce_cmd_yumi_o = lce_resp_v_o;
        if (stat_buf_v_i && line_dirty) begin
          state_n = e_wb_dirty_rd;
        end else if (lce_resp_v_o) begin
          state_n = e_ready;
        end
      end

      e_wb_dirty_rd: begin
        data_mem_pkt_o.opcode = e_data_read;
        data_mem_pkt_v_o = 1'b1;
        stat_mem_pkt_o.opcode = e_stat_clear_dirty;
        stat_mem_pkt_v_o = 1'b1;
        data_read_o = data_mem_pkt_yumi_i;
        if (data_mem_pkt_yumi_i && stat_mem_pkt_yumi_i) begin
          state_n = e_wb_dirty_send;
        end
      end

      e_wb_dirty_send: begin
        lce_resp_o.msg_type.resp = e_resp_wb;
        lce_resp_o.data = data_buf_i;
        resp_send = data_buf_v_i;
        lce_cmd_yumi_o = lce_resp_v_o;
        if (lce_resp_v_o) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

//--- verilog/lce_cmd.sv
// LCE command handler top
module lce_cmd (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [lce_pkg::lce_id_width-1:0] lce_id_i,
  output logic                            ready_o,
  output logic                            sync_done_o,

  output lce_pkg::tag_mem_pkt_s           tag_mem_pkt_o,
  output logic                            tag_mem_pkt_v_o,
  input  logic                            tag_mem_pkt_yumi_i,
  output lce_pkg::stat_mem_pkt_s          stat_mem_pkt_o,
  output logic                            stat_mem_pkt_v_o,
  input  logic                            stat_mem_pkt_yumi_i,
  input  lce_pkg::stat_info_s             stat_mem_i,
  output lce_pkg::data_mem_pkt_s          data_mem_pkt_o,
  output logic                            data_mem_pkt_v_o,
  input  logic                            data_mem_pkt_yumi_i,
  input  logic [lce_pkg::block_width-1:0] data_mem_i,

  output logic                            cache_req_complete_o,
  output logic                            uc_store_req_complete_o,

  input  lce_pkg::lce_cmd_msg_s           lce_cmd_i,
  input  logic                            lce_cmd_v_i,
  output logic                            lce_cmd_yumi_o,
  output lce_pkg::lce_resp_msg_s          lce_resp_o,
  output logic                            lce_resp_v_o,
  input  logic                            lce_resp_ready_i
);

  import lce_pkg::*;

  logic                   clear_step;
  logic                   sync_step;
  logic [cnt_width-1:0]   count;
  logic                   clear_last;
  logic                   sync_last;
  logic                   stat_read;
  logic                   data_read;
  stat_info_s             stat_buf;
  logic                   stat_buf_v;
  logic [block_width-1:0] data_buf;
  logic                   data_buf_v;

  lce_cmd_fsm i_fsm (
    .clk_i, .reset_i, .lce_id_i,
    .tag_mem_pkt_o, .tag_mem_pkt_v_o, .tag_mem_pkt_yumi_i,
    .stat_mem_pkt_o, .stat_mem_pkt_v_o, .stat_mem_pkt_yumi_i,
    .data_mem_pkt_o, .data_mem_pkt_v_o, .data_mem_pkt_yumi_i,
    .lce_cmd_i, .lce_cmd_v_i, .lce_cmd_yumi_o,
    .lce_resp_o, .lce_resp_v_o, .lce_resp_ready_i,
    .cache_req_complete_o, .uc_store_req_complete_o,
    .clear_step_o(clear_step), .sync_step_o(sync_step),
    .count_i(count), .clear_last_i(clear_last), .sync_last_i(sync_last),
    .ready_i(ready_o),
    .stat_read_o(stat_read), .data_read_o(data_read),
    .stat_buf_i(stat_buf), .stat_buf_v_i(stat_buf_v),
    .data_buf_i(data_buf), .data_buf_v_i(data_buf_v)
  );

  lce_init_sync i_init_sync (
    .clk_i, .reset_i,
    .clear_step_i(clear_step), .sync_step_i(sync_step),
    .count_o(count), .clear_last_o(clear_last), .sync_last_o(sync_last),
    .ready_o, .sync_done_o
  );

  // dirty bits of the set read for a writeback
  lce_read_buffer #(.width(assoc)) i_stat_buf (
    .clk_i, .reset_i, .read_i(stat_read), .mem_i(stat_mem_i),
    .buf_o(stat_buf), .buf_v_o(stat_buf_v)
  );

  lce_read_buffer #(.width(block_width)) i_data_buf (
    .clk_i, .reset_i, .read_i(data_read), .mem_i(data_mem_i),
    .buf_o(data_buf), .buf_v_o(data_buf_v)
  );

endmodule

//--- sim/cache_mem_model.sv
// Cache memory model
module cache_mem_model (
  input  logic                            clk_i,
  input  lce_pkg::tag_mem_pkt_s           tag_pkt_i,
  input  logic                            tag_v_i,
  output logic                            tag_yumi_o,
  input  lce_pkg::stat_mem_pkt_s          stat_pkt_i,
  input  logic                            stat_v_i,
  output logic                            stat_yumi_o,
  output lce_pkg::stat_info_s             stat_mem_o,
  input  lce_pkg::data_mem_pkt_s          data_pkt_i,
  input  logic                            data_v_i,
  output logic                            data_yumi_o,
  output logic [lce_pkg::block_width-1:0] data_mem_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import lce_pkg::*;

  logic [tag_width-1:0]   tags [sets][assoc];
  coh_state_e             states [sets][assoc];
  logic [assoc-1:0]       dirty [sets];
  logic [assoc-1:0]       dirty_preset [sets];
  logic [block_width-1:0] blocks [sets][assoc];
  logic                   tag_grant;
  logic                   stat_grant;
  logic                   data_grant;
  integer                 seed = 32'hfd26_2e93;
  logic [31:0]            roll;

  initial begin
    for (int s = 0; s < sets; s++) begin
      dirty_preset[s] = '0;
      for (int w = 0; w < assoc; w++) begin
        tags[s][w] = '0;
        states[s][w] = e_coh_i;
        blocks[s][w] = {8{16'(s * assoc + w) ^ 16'ha5c3}};
      end
    end
    // lines the writeback rows find dirty
    dirty_preset[9]  = 8'b0000_1000;
    dirty_preset[12] = 8'b0100_0000;
    for (int s = 0; s < sets; s++) begin
      dirty[s] = dirty_preset[s];
    end
    tag_grant = 1'b0;
    stat_grant = 1'b0;
    data_grant = 1'b0;
    stat_mem_o = '0;
    data_mem_o = '0;
  end

  // new random grants each falling edge
  always @(negedge clk_i) begin
    roll = $random(seed);
    tag_grant = roll[0];
    stat_grant = roll[1];
    data_grant = roll[2];
  end

  assign tag_yumi_o  = tag_v_i & tag_grant;
  assign stat_yumi_o = stat_v_i & stat_grant;
  assign data_yumi_o = data_v_i & data_grant;

  always @(posedge clk_i) begin
    if (tag_yumi_o) begin
      case (tag_pkt_i.opcode)
        e_tag_set_clear: begin
          for (int w = 0; w < assoc; w++) begin
            tags[tag_pkt_i.index][w] <= '0;
            states[tag_pkt_i.index][w] <= e_coh_i;
          end
        end
        e_tag_set_state: states[tag_pkt_i.index][tag_pkt_i.way_id] <= tag_pkt_i.state;
        default: begin
          tags[tag_pkt_i.index][tag_pkt_i.way_id] <= tag_pkt_i.tag;
          states[tag_pkt_i.index][tag_pkt_i.way_id] <= tag_pkt_i.state;
        end
      endcase
    end
    if (stat_yumi_o) begin
      case (stat_pkt_i.opcode)
        // the clear brings the set back to its preset dirty map
        e_stat_set_clear: dirty[stat_pkt_i.index] <= dirty_preset[stat_pkt_i.index];
        e_stat_read: stat_mem_o.dirty <= dirty[stat_pkt_i.index];
        default: dirty[stat_pkt_i.index][stat_pkt_i.way_id] <= 1'b0;
      endcase
    end
    if (data_yumi_o) begin
      if (data_pkt_i.opcode == e_data_write) begin
        blocks[data_pkt_i.index][data_pkt_i.way_id] <= data_pkt_i.data;
      end else begin
        data_mem_o <= blocks[data_pkt_i.index][data_pkt_i.way_id];
      end
    end
  end

endmodule

//--- sim/lce_cmd_tb.sv
// LCE command handler testbench
module lce_cmd_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lce_pkg::*;

  typedef struct {
    cmd_type_e              op;
    logic [tag_width-1:0]   tag;
    int                     idx;
    logic [paddr_width-1:0] addr;
    logic [3:0]             src;
    logic [way_width-1:0]   way;
    coh_state_e             st;
    logic [block_width-1:0] data;
    bit                     has_resp;
    resp_type_e             resp;
    int                     done_kind;
  } row_s;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic [lce_id_width-1:0] lce_id = 4'h3;
  logic ready, sync_done, cache_done, uc_done;
  tag_mem_pkt_s tag_pkt;
  stat_mem_pkt_s stat_pkt;
  data_mem_pkt_s data_pkt;
  logic tag_v, tag_yumi, stat_v, stat_yumi, data_v, data_yumi;
  stat_info_s stat_mem;
  logic [block_width-1:0] data_mem;
  lce_cmd_msg_s cmd = '0;
  logic cmd_v = 1'b0;
  logic cmd_yumi;
  lce_resp_msg_s resp;
  logic resp_v;
  logic resp_ready = 1'b0;

  row_s rows[$];
  lce_resp_msg_s seen_resp[$];
  bit clear_seen [sets];
  int clear_pairs = 0;
  int cache_pulses = 0;
  int uc_pulses = 0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cycle_limit = 100000;
  integer seed = 32'hfd26_2e93;
  logic [31:0] roll;

  lce_cmd i_dut (
    .clk_i(clk), .reset_i(reset), .lce_id_i(lce_id), .ready_o(ready),
    .sync_done_o(sync_done),
    .tag_mem_pkt_o(tag_pkt), .tag_mem_pkt_v_o(tag_v), .tag_mem_pkt_yumi_i(tag_yumi),
    .stat_mem_pkt_o(stat_pkt), .stat_mem_pkt_v_o(stat_v), .stat_mem_pkt_yumi_i(stat_yumi),
    .stat_mem_i(stat_mem),
    .data_mem_pkt_o(data_pkt), .data_mem_pkt_v_o(data_v), .data_mem_pkt_yumi_i(data_yumi),
    .data_mem_i(data_mem),
    .cache_req_complete_o(cache_done), .uc_store_req_complete_o(uc_done),
    .lce_cmd_i(cmd), .lce_cmd_v_i(cmd_v), .lce_cmd_yumi_o(cmd_yumi),
    .lce_resp_o(resp), .lce_resp_v_o(resp_v), .lce_resp_ready_i(resp_ready)
  );

  cache_mem_model i_mem (
    .clk_i(clk),
    .tag_pkt_i(tag_pkt), .tag_v_i(tag_v), .tag_yumi_o(tag_yumi),
    .stat_pkt_i(stat_pkt), .stat_v_i(stat_v), .stat_yumi_o(stat_yumi),
    .stat_mem_o(stat_mem),
    .data_pkt_i(data_pkt), .data_v_i(data_v), .data_yumi_o(data_yumi),
    .data_mem_o(data_mem)
  );

  always #50 clk = ~clk;

  task automatic check(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("mismatch at %0t: %s", $time, what);
    end
  endtask

  task automatic add_row(input cmd_type_e op, input logic [21:0] tag, input int idx,
                         input int way, input coh_state_e st, input logic [127:0] data,
                         input bit has_resp, input resp_type_e rt, input int done_kind);
    row_s r;
    r.op = op;
    r.tag = tag;
    r.idx = idx;
    r.addr = {tag, 6'(idx), 4'h0};
    r.src = 4'(idx % 2);
    r.way = 3'(way);
    r.st = st;
    r.data = data;
    r.has_resp = has_resp;
    r.resp = rt;
    r.done_kind = done_kind;
    rows.push_back(r);
  endtask

  // random response back-pressure
  always @(negedge clk) begin
    roll = $random(seed);
    resp_ready <= roll[0];
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the DUT stopped making progress after %0d cycles", cycles);
      $display("errors: %0d, checks: %0d", errors, checks);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // watch the clear walk, responses and completion pulses
  always @(posedge clk) begin
    if (!reset && tag_v && tag_yumi && stat_v && stat_yumi &&
        tag_pkt.opcode == e_tag_set_clear && stat_pkt.opcode == e_stat_set_clear) begin
      check(!clear_seen[tag_pkt.index], $sformatf("index %0d cleared twice", tag_pkt.index));
      check(!ready, "ready high during the clear walk");
      clear_seen[tag_pkt.index] = 1'b1;
      clear_pairs++;
    end
    if (resp_v) begin
      check(resp_ready, "response valid without ready");
      seen_resp.push_back(resp);
    end
    if (cache_done) begin
      check(cmd_yumi, "cache_req_complete without command yumi");
      cache_pulses++;
    end
    if (uc_done) begin
      uc_pulses++;
    end
  end

  initial begin
    row_s r;
    int idx;
    int cache_before;
    int uc_before;
    logic [block_width-1:0] exp_data;

    add_row(e_cmd_sync, 22'h0, 0, 0, e_coh_i, '0, 1, e_resp_sync_ack, 0);
    add_row(e_cmd_sync, 22'h0, 1, 0, e_coh_i, '0, 1, e_resp_sync_ack, 0);
    add_row(e_cmd_data, 22'h01234, 5, 2, e_coh_e, {4{32'hc0de_0005}}, 1, e_resp_coh_ack, 1);
    add_row(e_cmd_st, 22'h01234, 5, 2, e_coh_s, '0, 0, e_resp_sync_ack, 0);
    add_row(e_cmd_inv, 22'h01234, 5, 2, e_coh_m, '0, 1, e_resp_inv_ack, 0);
    add_row(e_cmd_wb, 22'h00abc, 9, 1, e_coh_i, '0, 1, e_resp_null_wb, 0);
    add_row(e_cmd_wb, 22'h00def, 12, 6, e_coh_i, '0, 1, e_resp_wb, 0);
    add_row(e_cmd_wb, 22'h00def, 12, 6, e_coh_i, '0, 1, e_resp_null_wb, 0);
    add_row(e_cmd_uc_st_done, 22'h0, 3, 0, e_coh_i, '0, 0, e_resp_sync_ack, 2);
    add_row(e_cmd_data, 22'h3ffff, 63, 7, e_coh_m, {2{64'h0123_4567_89ab_cdef}}, 1,
            e_resp_coh_ack, 1);
    // random grants pass a clear pair about one cycle in four
    cycle_limit = 20 + sets * 40 + rows.size() * 80;

    repeat (10) @(negedge clk);
    reset = 1'b0;
    while (!ready) @(negedge clk);
    check(clear_pairs == sets, $sformatf("%0d clear pairs before ready", clear_pairs));

    for (int n = 0; n < rows.size(); n++) begin
      r = rows[n];
      idx = r.idx;
      seen_resp.delete();
      cache_before = cache_pulses;
      uc_before = uc_pulses;
      exp_data = (r.resp == e_resp_wb) ? i_mem.blocks[idx][r.way] : '0;
      check(!sync_done || n > 1, "sync_done high before the last sync");
      cmd = '0;
      cmd.msg_type.cmd = r.op;
      cmd.addr = r.addr;
      cmd.src_id = r.src;
      cmd.way_id = r.way;
      cmd.state = r.st;
      cmd.data = r.data;
      cmd_v = 1'b1;
      forever begin
        @(posedge clk);
        if (cmd_yumi) break;
      end
      @(negedge clk);
      cmd_v = 1'b0;

      check(seen_resp.size() == int'(r.has_resp),
            $sformatf("row %0d gave %0d responses", n, seen_resp.size()));
      if (r.has_resp && seen_resp.size() == 1) begin
        check(seen_resp[0].msg_type.resp == r.resp, $sformatf("row %0d response type", n));
        check(seen_resp[0].addr == r.addr, $sformatf("row %0d response address", n));
        check(seen_resp[0].src_id == lce_id, $sformatf("row %0d response src_id", n));
        check(seen_resp[0].dst_id == r.src, $sformatf("row %0d response dst_id", n));
        if (r.op == e_cmd_wb) begin
          check(seen_resp[0].data == exp_data, $sformatf("row %0d writeback data", n));
        end
      end
      check(cache_pulses - cache_before == int'(r.done_kind == 1),
            $sformatf("row %0d cache_req_complete pulses", n));
      check(uc_pulses - uc_before == int'(r.done_kind == 2),
            $sformatf("row %0d uc_store_req_complete pulses", n));

      case (r.op)
        e_cmd_sync: check(sync_done == (n == num_cce - 1), $sformatf("row %0d sync_done", n));
        e_cmd_inv: check(i_mem.states[idx][r.way] == e_coh_i, "invalidated state");
        e_cmd_st: check(i_mem.states[idx][r.way] == r.st, "set state");
        e_cmd_data: begin
          check(i_mem.tags[idx][r.way] == r.tag, "filled tag");
          check(i_mem.states[idx][r.way] == r.st, "filled state");
          check(i_mem.blocks[idx][r.way] == r.data, "filled block");
        end
        e_cmd_wb: check(!i_mem.dirty[idx][r.way], "dirty bit after writeback");
        default: ;
      endcase
    end

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- lce_cmd.f
verilog/lce_pkg.sv
verilog/lce_read_buffer.sv
verilog/lce_init_sync.sv
verilog/lce_cmd_fsm.sv
verilog/lce_cmd.sv
sim/cache_mem_model.sv
sim/lce_cmd_tb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing -Wno-fatal
TOP      ?= lce_cmd_tb
FILELIST ?= lce_cmd.f
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
